/* design/aes_defs.svh */
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// block, state and round key are all one width
`define AES_BLOCK_W      128

// aes-256 runs 14 rounds over 15 round keys
`define AES_NUM_ROUNDS   14
`define AES_NUM_RKEYS    15
`define AES_RKEY_ADDR_W  4

// host mode codes on din_mode
`define AES_MODE_ENC     2'd0
`define AES_MODE_DEC     2'd1
`define AES_MODE_KEY     2'd2
`define AES_MODE_END     2'd3

`endif

/* design/aes_pkg.sv */
`default_nettype none
`include "aes_defs.svh"

package aes_pkg;

    // byte 0 of the fips-197 string sits in the top bits
    typedef logic [`AES_BLOCK_W-1:0] block_t;
    typedef logic [`AES_RKEY_ADDR_W-1:0] rkey_addr_t;

    typedef enum logic [1:0] {
        mode_enc = `AES_MODE_ENC,
        mode_dec = `AES_MODE_DEC,
        mode_key = `AES_MODE_KEY,
        mode_end = `AES_MODE_END
    } mode_e;

    // forward s-box, entry 0 leftmost
    localparam logic [0:255][7:0] sbox = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // key schedule word substitution, no rotation here
    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {sbox[w[31:24]], sbox[w[23:16]], sbox[w[15:8]], sbox[w[7:0]]};
    endfunction

    function automatic block_t sub_bytes(input block_t s);
        block_t r;
        for (int i = 0; i < 16; i++)
            r[i*8 +: 8] = sbox[s[i*8 +: 8]];
        return r;
    endfunction

    // row r rotates left by r columns
    function automatic block_t shift_rows(input block_t s);
        block_t r;
        for (int c = 0; c < 4; c++)
            for (int row = 0; row < 4; row++)
                r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c + row) % 4) + row) -: 8];
        return r;
    endfunction

    function automatic block_t mix_columns(input block_t s);
        block_t r;
        logic [7:0] a [4];
        logic [7:0] x [4];
        for (int c = 0; c < 4; c++)
        begin
            // x holds 2*a in gf(2^8)
            for (int i = 0; i < 4; i++)
            begin
                a[i] = s[127 - 8*(4*c + i) -: 8];
                x[i] = {a[i][6:0], 1'b0} ^ (a[i][7] ? 8'h1b : 8'h00);
            end
            // 2*a0 ^ 3*a1 ^ a2 ^ a3, rotated per output row
            for (int i = 0; i < 4; i++)
                r[127 - 8*(4*c + i) -: 8] = x[i] ^ x[(i+1)%4] ^ a[(i+1)%4]
                                            ^ a[(i+2)%4] ^ a[(i+3)%4];
        end
        return r;
    endfunction

endpackage

`default_nettype wire

/* design/key_store_if.sv */
`timescale 1ns/10ps
`default_nettype none
`include "aes_defs.svh"

interface key_store_if;
    // write side, filled by the key schedule
    logic                        wr_en;
    logic [`AES_RKEY_ADDR_W-1:0] wr_addr;
    logic [`AES_BLOCK_W-1:0]     wr_key;
    // read side, rd_key lags rd_addr by one clock
    logic [`AES_RKEY_ADDR_W-1:0] rd_addr;
    logic [`AES_BLOCK_W-1:0]     rd_key;

    modport writer (output wr_en, output wr_addr, output wr_key);
    modport reader (output rd_addr, input rd_key);
    modport store (input wr_en, input wr_addr, input wr_key, input rd_addr, output rd_key);
endinterface

`default_nettype wire

/* design/aes_round_key_store.sv */
`timescale 1ns/10ps
`default_nettype none
`include "aes_defs.svh"

module aes_round_key_store (
    input  logic       clk,
    input  logic       resetn,
    key_store_if.store ks
);
    aes_pkg::block_t mem [`AES_NUM_RKEYS];

    // one write port, driven by the schedule
    always_ff @(posedge clk)
    begin
        if (ks.wr_en)
            mem[ks.wr_addr] <= ks.wr_key;
    end

    // registered read, key arrives the cycle after its address
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            ks.rd_key <= '0;
        else
            ks.rd_key <= mem[ks.rd_addr];
    end

    wr_addr_range: assert property (@(posedge clk) disable iff (!resetn)
        ks.wr_en |-> (ks.wr_addr < `AES_NUM_RKEYS))
        else $error("round-key write beyond the last entry");

endmodule

`default_nettype wire

/* design/aes_key_expand.sv */
`timescale 1ns/10ps
`default_nettype none
`include "aes_defs.svh"

module aes_key_expand (
    input  logic            clk,
    input  logic            resetn,
    input  aes_pkg::block_t key_lo,
    input  aes_pkg::block_t key_hi,
    input  logic            expand_start,
    output logic            expand_done,
    key_store_if.writer     ks
);
    localparam aes_pkg::rkey_addr_t last_idx = aes_pkg::rkey_addr_t'(`AES_NUM_RKEYS - 1);

    // eight-word window, cur goes out this cycle and nxt follows
    aes_pkg::block_t     cur;
    aes_pkg::block_t     nxt;
    logic [7:0]          rcon;
    aes_pkg::rkey_addr_t idx;
    logic                busy;
    logic [31:0]         last_w;
    logic [31:0]         temp;
    logic [31:0]         w0;
    logic [31:0]         w1;
    logic [31:0]         w2;
    logic [31:0]         w3;

    assign last_w = nxt[31:0];

    // key idx+2 has the parity of idx
    always_comb
    begin
        if (idx[0])
            temp = aes_pkg::sub_word(last_w);
        else
            temp = aes_pkg::sub_word({last_w[23:0], last_w[31:24]}) ^ {rcon, 24'h0};
        w0 = cur[127:96] ^ temp;
        w1 = cur[95:64] ^ w0;
        w2 = cur[63:32] ^ w1;
        w3 = cur[31:0] ^ w2;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy <= 1'b0;
            idx  <= '0;
        end
        else if (expand_start)
        begin
            busy <= 1'b1;
            idx  <= '0;
        end
        else if (busy)
        begin
            idx <= idx + 1'b1;
            if (idx == last_idx)
                busy <= 1'b0;
        end
    end

    // key_lo is round key 0, key_hi round key 1
    always_ff @(posedge clk)
    begin
        if (expand_start)
        begin
            cur  <= key_lo;
            nxt  <= key_hi;
            rcon <= 8'h01;
        end
        else if (busy)
        begin
            cur <= nxt;
            nxt <= {w0, w1, w2, w3};
            // rcon steps only after an even key used it
            if (!idx[0])
                rcon <= {rcon[6:0], 1'b0};
        end
    end

    assign ks.wr_en   = busy;
    assign ks.wr_addr = idx;
    assign ks.wr_key  = cur;
    assign expand_done = busy && (idx == last_idx);

    // the store sees exactly fifteen writes per start
    write_burst: assert property (@(posedge clk) disable iff (!resetn)
        expand_start |=> ks.wr_en [*`AES_NUM_RKEYS] ##1 !ks.wr_en)
        else $error("round-key write burst has the wrong length");

endmodule

`default_nettype wire

/* design/aes_enc_core.sv */
`timescale 1ns/10ps
`default_nettype none
`include "aes_defs.svh"

module aes_enc_core (
    input  logic            clk,
    input  logic            resetn,
    input  aes_pkg::block_t enc_in,
    input  logic            enc_start,
    output aes_pkg::block_t enc_out,
    output logic            enc_done,
    key_store_if.reader     ks
);
    localparam aes_pkg::rkey_addr_t last_rnd = aes_pkg::rkey_addr_t'(`AES_NUM_ROUNDS);

    aes_pkg::block_t     state;
    // round being applied, 0 when idle
    aes_pkg::rkey_addr_t rnd;
    aes_pkg::block_t     shifted;
    aes_pkg::block_t     mixed;
    logic                busy;

    assign busy    = (rnd != '0);
    assign shifted = aes_pkg::shift_rows(aes_pkg::sub_bytes(state));
    assign mixed   = aes_pkg::mix_columns(shifted);

    // last round has no mix-columns
    assign enc_out  = ((rnd == last_rnd) ? shifted : mixed) ^ ks.rd_key;
    assign enc_done = (rnd == last_rnd);

    // fetch one key ahead, idle parks on key 0 for the initial add
    always_comb
    begin
        if (enc_start)
            ks.rd_addr = aes_pkg::rkey_addr_t'(1);
        else if (busy && rnd != last_rnd)
            ks.rd_addr = rnd + 1'b1;
        else
            ks.rd_addr = '0;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            rnd <= '0;
        else if (enc_start)
            rnd <= aes_pkg::rkey_addr_t'(1);
        else if (busy)
            rnd <= (rnd == last_rnd) ? '0 : rnd + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        // initial add-round-key in the start cycle
        if (enc_start)
            state <= enc_in ^ ks.rd_key;
        else if (busy)
            state <= enc_out;
    end

    no_overlap: assert property (@(posedge clk) disable iff (!resetn)
        enc_start |-> !busy)
        else $error("enc_start while a block is in flight");

    // start cycle plus fourteen rounds
    done_latency: assert property (@(posedge clk) disable iff (!resetn)
        enc_start |-> ##(`AES_NUM_ROUNDS) enc_done)
        else $error("enc_done not on the last round");

endmodule

`default_nettype wire

/* design/aes_device_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module aes_device_ctrl (
    input  logic            clk,
    input  logic            resetn,
    input  aes_pkg::block_t din,
    input  logic [1:0]      din_mode,
    input  logic            din_valid,
    output logic            din_ack,
    output aes_pkg::block_t dout,
    output logic            dout_valid,
    output aes_pkg::block_t key_lo,
    output aes_pkg::block_t key_hi,
    output logic            expand_start,
    input  logic            expand_done,
    output aes_pkg::block_t enc_in,
    output logic            enc_start,
    input  aes_pkg::block_t enc_out,
    input  logic            enc_done
);
    // key_wait is the single cycle in which expand_start is high
    typedef enum logic [2:0] {
        st_idle,
        st_accept,
        st_key_wait,
        st_expand,
        st_encrypt
    } state_e;

    state_e         state;
    aes_pkg::mode_e cmd_mode;
    aes_pkg::mode_e in_mode;
    // halves received so far, 0..2
    logic [1:0]     key_cnt;
    logic           key_valid;
    logic           take;

    assign in_mode = aes_pkg::mode_e'(din_mode);

    // enc is held off until a full key set sits in the store
    assign take = (state == st_idle) && din_valid
                  && ((in_mode != aes_pkg::mode_enc) || key_valid);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state        <= st_idle;
            cmd_mode     <= aes_pkg::mode_enc;
            key_cnt      <= '0;
            key_valid    <= 1'b0;
            din_ack      <= 1'b0;
            expand_start <= 1'b0;
            enc_start    <= 1'b0;
        end
        else
        begin
            // all three are single-cycle pulses
            din_ack      <= 1'b0;
            expand_start <= 1'b0;
            enc_start    <= 1'b0;
            case (state)
                st_idle:
                    if (take)
                    begin
                        din_ack  <= 1'b1;
                        cmd_mode <= in_mode;
                        state    <= st_accept;
                        // a new key half drops the old set
                        if (in_mode == aes_pkg::mode_key)
                        begin
                            key_cnt   <= key_cnt + 1'b1;
                            key_valid <= 1'b0;
                        end
                    end
                st_accept:
                    case (cmd_mode)
                        aes_pkg::mode_key:
                            if (key_cnt == 2'd2)
                            begin
                                key_cnt      <= '0;
                                expand_start <= 1'b1;
                                state        <= st_key_wait;
                            end
                            else
                                state <= st_idle;
                        aes_pkg::mode_enc:
                        begin
                            enc_start <= 1'b1;
                            state     <= st_encrypt;
                        end
                        // dec and end are swallowed here
                        default:
                            state <= st_idle;
                    endcase
                st_key_wait:
                    state <= st_expand;
                st_expand:
                    if (expand_done)
                    begin
                        key_valid <= 1'b1;
                        state     <= st_idle;
                    end
                st_encrypt:
                    if (enc_done)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    // capture data while the host still holds it
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            if (in_mode == aes_pkg::mode_key && key_cnt == 2'd0)
                key_lo <= din;
            if (in_mode == aes_pkg::mode_key && key_cnt == 2'd1)
                key_hi <= din;
            if (in_mode == aes_pkg::mode_enc)
                enc_in <= din;
        end
    end

    // result register, dout holds until the next block
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            dout       <= '0;
            dout_valid <= 1'b0;
        end
        else
        begin
            dout_valid <= enc_done;
            if (enc_done)
                dout <= enc_out;
        end
    end

    ack_single_pulse: assert property (@(posedge clk) disable iff (!resetn)
        din_ack |=> !din_ack)
        else $error("din_ack high on two consecutive cycles");

    // the core must never run on a half-written key set
    enc_needs_keys: assert property (@(posedge clk) disable iff (!resetn)
        enc_start |-> key_valid)
        else $error("enc_start without a valid key set");

endmodule

`default_nettype wire

/* design/aes_device.sv */
`timescale 1ns/10ps
`default_nettype none

module aes_device (
    input  logic            clk,
    input  logic            resetn,
    input  aes_pkg::block_t din,
    input  logic [1:0]      din_mode,
    input  logic            din_valid,
    output logic            din_ack,
    output aes_pkg::block_t dout,
    output logic            dout_valid
);
    // controller to key schedule
    aes_pkg::block_t key_lo;
    aes_pkg::block_t key_hi;
    logic            expand_start;
    logic            expand_done;
    // controller to cipher core
    aes_pkg::block_t enc_in;
    aes_pkg::block_t enc_out;
    logic            enc_start;
    logic            enc_done;

    // round keys go through the store, schedule writes and core reads
    key_store_if ks_bus ();

    aes_device_ctrl ctrl0 (
        .clk          (clk),
        .resetn       (resetn),
        .din          (din),
        .din_mode     (din_mode),
        .din_valid    (din_valid),
        .din_ack      (din_ack),
        .dout         (dout),
        .dout_valid   (dout_valid),
        .key_lo       (key_lo),
        .key_hi       (key_hi),
        .expand_start (expand_start),
        .expand_done  (expand_done),
        .enc_in       (enc_in),
        .enc_start    (enc_start),
        .enc_out      (enc_out),
        .enc_done     (enc_done)
    );

    aes_key_expand key_expand0 (
        .clk          (clk),
        .resetn       (resetn),
        .key_lo       (key_lo),
        .key_hi       (key_hi),
        .expand_start (expand_start),
        .expand_done  (expand_done),
        .ks           (ks_bus.writer)
    );

    aes_round_key_store key_store0 (
        .clk    (clk),
        .resetn (resetn),
        .ks     (ks_bus.store)
    );

    aes_enc_core enc_core0 (
        .clk       (clk),
        .resetn    (resetn),
        .enc_in    (enc_in),
        .enc_start (enc_start),
        .enc_out   (enc_out),
        .enc_done  (enc_done),
        .ks        (ks_bus.reader)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int clk_period   = 100,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic resetn
);
    // free-running clock, first rising edge at half a period
    initial
    begin
        clk = 1'b0;
        forever
            #(clk_period / 2) clk = ~clk;
    end

    // starts high for 1 ns so the drop is a real falling edge
    initial
    begin
        resetn = 1'b1;
        #1;
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        // release away from the rising edge
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/aes_device_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "aes_defs.svh"

module aes_device_tb;
    localparam int drive_delay   = 10;
    localparam int cycle_limit   = 400;
    localparam int no_key_cycles = 40;
    localparam int quiet_cycles  = 20;
    localparam int enc_latency   = 16;

    // fips-197 aes-256 example with the low half as round key 0
    localparam aes_pkg::block_t fips_key_lo = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_pkg::block_t fips_key_hi = 128'h101112131415161718191a1b1c1d1e1f;
    localparam aes_pkg::block_t fips_pt     = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::block_t fips_ct     = 128'h8ea2b7ca516745bfeafc49904b496089;
    // all-zero key with all-zero block
    localparam aes_pkg::block_t zero_ct     = 128'hdc95c078a2408989ad48a21492842087;

    logic            clk;
    logic            resetn;
    aes_pkg::block_t din;
    logic [1:0]      din_mode;
    logic            din_valid;
    logic            din_ack;
    aes_pkg::block_t dout;
    logic            dout_valid;

    // stimulus state seen by the checks
    aes_pkg::block_t expected_ct;
    logic            awaiting_ack;
    logic            enc_no_key;
    int              errors       = 0;
    int              ack_count    = 0;
    int              result_count = 0;
    int              cycles       = 0;
    integer          seed;

    tb_clock_gen #(
        .clk_period   (100),
        .reset_cycles (2)
    ) clock_gen0 (
        .clk    (clk),
        .resetn (resetn)
    );

    aes_device dut0 (
        .clk        (clk),
        .resetn     (resetn),
        .din        (din),
        .din_mode   (din_mode),
        .din_valid  (din_valid),
        .din_ack    (din_ack),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

    // put a command on the bus and hold it
    task automatic drive_command(input logic [1:0] mode, input aes_pkg::block_t data);
        din          = data;
        din_mode     = mode;
        din_valid    = 1'b1;
        awaiting_ack = 1'b1;
    endtask

    // hold the command through the edge that samples the ack
    task automatic finish_handshake();
        do
        begin
            @(posedge clk);
            #drive_delay;
        end
        while (!din_ack);
        @(posedge clk);
        #drive_delay;
        din_valid    = 1'b0;
        awaiting_ack = 1'b0;
    endtask

    task automatic send_command(input logic [1:0] mode, input aes_pkg::block_t data);
        drive_command(mode, data);
        finish_handshake();
    endtask

    // stays on the drive slot after each edge
    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #drive_delay;
        end
    endtask

    task automatic idle_gap();
        int n;
        n = $unsigned($random(seed)) % 4;
        wait_cycles(n);
    endtask

    task automatic wait_for_result();
        do
        begin
            @(posedge clk);
            #drive_delay;
        end
        while (!dout_valid);
    endtask

    task automatic encrypt_block(input aes_pkg::block_t pt, input aes_pkg::block_t ct);
        expected_ct = ct;
        send_command(`AES_MODE_ENC, pt);
        wait_for_result();
    endtask

    always @(posedge clk)
    begin
        if (din_ack)
            ack_count++;
        if (dout_valid)
            result_count++;
    end

    initial
    begin
        din          = '0;
        din_mode     = `AES_MODE_ENC;
        din_valid    = 1'b0;
        awaiting_ack = 1'b0;
        enc_no_key   = 1'b0;
        expected_ct  = '0;
        seed         = 1233;
        // only the release after the low phase counts
        wait (resetn === 1'b0);
        @(posedge resetn);
        wait_cycles(1);

        // enc before any key must stall and is then withdrawn
        din        = fips_pt;
        din_mode   = `AES_MODE_ENC;
        din_valid  = 1'b1;
        enc_no_key = 1'b1;
        wait_cycles(no_key_cycles);
        din_valid  = 1'b0;
        enc_no_key = 1'b0;

        idle_gap();
        send_command(`AES_MODE_KEY, fips_key_lo);
        idle_gap();
        send_command(`AES_MODE_KEY, fips_key_hi);
        // enc issued during expansion waits for a valid key set
        idle_gap();
        encrypt_block(fips_pt, fips_ct);

        // dec and end are swallowed
        idle_gap();
        send_command(`AES_MODE_DEC, fips_ct);
        wait_cycles(quiet_cycles);
        idle_gap();
        send_command(`AES_MODE_END, '0);
        wait_cycles(quiet_cycles);

        // reload with the zero key
        idle_gap();
        send_command(`AES_MODE_KEY, '0);
        idle_gap();
        send_command(`AES_MODE_KEY, '0);
        idle_gap();
        encrypt_block('0, zero_ct);
        wait_cycles(4);

        $display("summary: %0d errors, %0d acks, %0d results", errors, ack_count, result_count);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // watchdog at about twice the sequence length
    initial
    begin
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the test sequence did not finish within %0d cycles", cycle_limit);
        $display("summary: %0d errors, %0d acks, %0d results", errors, ack_count, result_count);
        $display("Result: FAILED");
        $finish;
    end

    reset_outputs: assert property (@(posedge clk)
        (!resetn || $rose(resetn)) |-> (!din_ack && !dout_valid && dout == '0))
        else
        begin
            errors++;
            $display("[FAIL] %0t: outputs not cleared by reset", $time);
        end

    no_ack_without_key: assert property (@(posedge clk) disable iff (!resetn)
        enc_no_key |-> !din_ack)
        else
        begin
            errors++;
            $display("[FAIL] %0t: enc acknowledged with no key loaded", $time);
        end

    // every ack belongs to a held command
    ack_matches_command: assert property (@(posedge clk) disable iff (!resetn)
        din_ack |-> (awaiting_ack && din_valid))
        else
        begin
            errors++;
            $display("[FAIL] %0t: din_ack without a pending command", $time);
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        din_ack |=> !din_ack)
        else
        begin
            errors++;
            $display("[FAIL] %0t: din_ack longer than one cycle", $time);
        end

    enc_result_latency: assert property (@(posedge clk) disable iff (!resetn)
        (din_ack && din_mode == `AES_MODE_ENC)
        |-> ##1 (!dout_valid) [*(enc_latency - 1)] ##1 dout_valid)
        else
        begin
            errors++;
            $display("[FAIL] %0t: dout_valid not 16 cycles after enc ack", $time);
        end

    ciphertext_value: assert property (@(posedge clk) disable iff (!resetn)
        dout_valid |-> (dout == expected_ct))
        else
        begin
            errors++;
            $display("[FAIL] %0t: dout %h, expected %h", $time, dout, expected_ct);
        end

    no_output_after_dec_end: assert property (@(posedge clk) disable iff (!resetn)
        (din_ack && (din_mode == `AES_MODE_DEC || din_mode == `AES_MODE_END))
        |=> (!dout_valid) [*quiet_cycles])
        else
        begin
            errors++;
            $display("[FAIL] %0t: dout_valid after a dec or end command", $time);
        end

    // result held between pulses
    dout_holds: assert property (@(posedge clk) disable iff (!resetn)
        !dout_valid |-> $stable(dout))
        else
        begin
            errors++;
            $display("[FAIL] %0t: dout changed without dout_valid", $time);
        end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/aes_pkg.sv
design/key_store_if.sv
design/aes_round_key_store.sv
design/aes_key_expand.sv
design/aes_enc_core.sv
design/aes_device_ctrl.sv
design/aes_device.sv
verification/tb_clock_gen.sv
verification/aes_device_tb.sv

/* Bender.yml */
package:
  name: aes_device

sources:
  - include_dirs:
      - design
    files:
      - design/aes_pkg.sv
      - design/key_store_if.sv
      - design/aes_round_key_store.sv
      - design/aes_key_expand.sv
      - design/aes_enc_core.sv
      - design/aes_device_ctrl.sv
      - design/aes_device.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/tb_clock_gen.sv
      - verification/aes_device_tb.sv
